// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = tb_ddr_cmd
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log
FAIL_MSG  = Finished with errors
PASS_MSG  = Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	@if grep -q "$(FAIL_MSG)" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "$(PASS_MSG)" $(LOG); then echo "simulation did not complete"; exit 1; fi
	@echo "simulation PASSED"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: bank_tracker.sv
`timescale 1ns/1ps

module bank_tracker #(
  parameter int unsigned T_CMD_RELOAD = 12,
  parameter int unsigned T_REF_RELOAD = 3
) (
  input  logic     input_clock,
  input  logic     rst,
  input  logic     refresh_strobe,  // toggle
  state_if.tracker s
);
  import ddr_cmd_pkg::*;

  logic [CNT_W-1:0] counter;
  logic             ref_ack;     // strobe level at last refresh
  logic             write_hold;
  logic             norm_win;
  logic             dlay_win;

  // ------------------------------
  // issue window
  // ------------------------------
  // after a write with the page still open the window moves to 15/0.
  // hits wait for it too, since only the issuer knows about hits
  assign write_hold = s.page_active && s.last_write;

  assign norm_win = (counter == WIN_NORM_LO) || (counter == WIN_NORM_HI);
  assign dlay_win = (counter == WIN_DLAY_LO) || (counter == WIN_DLAY_HI);

  assign s.window_open = !s.settle && (write_hold ? dlay_win : norm_win);

  // ------------------------------
  // state update
  // ------------------------------
  always_ff @(posedge input_clock)
  begin
    if (!rst)
    begin
      s.page_active <= 1'b0;
      s.last_write  <= 1'b0;
      s.access_open <= 1'b0;
      s.refresh_due <= 1'b0;
      ref_ack       <= 1'b0;
      counter       <= CNT_RESET;
    end
    else
    begin
      s.refresh_due <= ref_ack ^ refresh_strobe;  // level change means refresh

      if (s.settle)
      begin
        case (s.issued_cmd)
          ACTV:    s.page_active <= 1'b1;
          PRCH:    s.page_active <= 1'b0;
          default: ;
        endcase

        if (s.issued_cmd == WRTE)
          s.last_write <= 1'b1;
        else if (s.issued_cmd != NOOP)
          s.last_write <= 1'b0;

        s.access_open <= (s.issued_cmd == READ) || (s.issued_cmd == WRTE);

        if (s.issued_cmd == ARSR)
          ref_ack <= refresh_strobe;

        case (s.issued_cmd)
          ARSR:                   counter <= CNT_W'(T_REF_RELOAD);  // longer recovery
          ACTV, PRCH, READ, WRTE: counter <= CNT_W'(T_CMD_RELOAD);
          default:                counter <= CNT_RESET;
        endcase
      end
      else if (!s.window_open)
        counter <= counter + 1'b1;
    end
  end

  // settle always reloads, the count never runs on from the old value
  a_settle_reload : assert property (
    @(posedge input_clock) disable iff (!rst)
    s.settle |=> ((counter == CNT_W'(T_CMD_RELOAD)) || (counter == CNT_W'(T_REF_RELOAD)))
  );

endmodule

// File: cmd_issuer.sv
`timescale 1ns/1ps

module cmd_issuer (
  input  logic                                 input_clock,
  input  logic                                 rst,
  match_if.sink                                m,
  state_if.issuer                              s,
  output logic                                 rand_grant,
  output logic                                 bulk_grant,
  output logic [ddr_cmd_pkg::SDRAM_ADDR_W-1:0] sdram_address,
  output logic [ddr_cmd_pkg::BANK_W-1:0]       sdram_bank,
  output ddr_cmd_pkg::ddr_cmd_e                command,
  output logic [ddr_cmd_pkg::WE_W-1:0]         we_array_out
);
  import ddr_cmd_pkg::*;

  ddr_cmd_e next_cmd;
  logic     hit;
  logic     same_dir;
  logic     run_ok;
  logic     override;
  logic     issue;
  logic     settle_q;

  assign hit      = m.rand_hit || m.bulk_hit;
  assign same_dir = (s.last_write == m.write_match);

  // ------------------------------
  // issue decision
  // ------------------------------
  assign run_ok   = s.window_open && s.access_open && hit && same_dir;
  assign override = s.window_open && (m.request_any || s.refresh_due);
  assign issue    = override || run_ok;

  always_comb
  begin
    if (hit)
      next_cmd = m.write_match ? WRTE : READ;
    else if (s.page_active)
      next_cmd = PRCH;  // miss or refresh, close first
    else if (s.refresh_due)
      next_cmd = ARSR;
    else
      next_cmd = ACTV;
  end

  // ------------------------------
  // output register
  // ------------------------------
  always_ff @(posedge input_clock)
  begin
    if (!rst)
    begin
      command       <= NOOP;
      settle_q      <= 1'b0;
      rand_grant    <= 1'b0;
      bulk_grant    <= 1'b0;
      sdram_address <= IDLE_ADDR;
      sdram_bank    <= '0;
      we_array_out  <= '0;
    end
    else
    begin
      settle_q   <= issue;
      rand_grant <= issue && m.rand_hit;  // one cycle pulse
      bulk_grant <= issue && m.bulk_hit;

      if (issue)
      begin
        command      <= next_cmd;
        we_array_out <= m.we_array;

        case (next_cmd)
          READ, WRTE:
          begin
            sdram_address <= {m.next_col, 1'b0};
            sdram_bank    <= m.next_page.bank;
          end
          ACTV:
          begin
            // row split around a10
            sdram_address <= {m.next_page.row[ROW_W-1:ROW_W-2], 1'b0,
                              m.next_page.row[ROW_W-3:0]};
            sdram_bank    <= m.next_page.bank;
          end
          default: sdram_address <= IDLE_ADDR;
        endcase
      end
      else
        command <= NOOP;
    end
  end

  assign s.issued_cmd = command;
  assign s.settle     = settle_q;

  // grants only ride on an access command
  a_grant_access : assert property (
    @(posedge input_clock) disable iff (!rst)
    (rand_grant || bulk_grant) |-> ((command == READ) || (command == WRTE))
  );

endmodule

// File: ddr_cmd_pkg.sv
package ddr_cmd_pkg;

  // ------------------------------
  // sdram command encodings
  // ------------------------------
  typedef enum logic [2:0] {
    NOOP = 3'b111,  // no operation
    ACTV = 3'b011,  // row open
    READ = 3'b101,
    WRTE = 3'b100,
    BTRM = 3'b110,  // burst terminate, never issued
    PRCH = 3'b010,  // row close
    ARSR = 3'b001,  // auto refresh
    MRST = 3'b000   // mode register set, never issued
  } ddr_cmd_e;

  // ------------------------------
  // address fields
  // ------------------------------
  localparam int ADDR_W       = 26;
  localparam int ROW_W        = 12;  // bits 25..14
  localparam int BANK_W       = 2;   // bits 13..12
  localparam int COL_W        = 12;  // bits 11..0
  localparam int SDRAM_ADDR_W = 13;
  localparam int WE_W         = 4;

  // open page, row above bank as in the port address
  typedef struct packed {
    logic [ROW_W-1:0]  row;
    logic [BANK_W-1:0] bank;
  } page_t;

  // a10 set, all-banks precharge
  localparam logic [SDRAM_ADDR_W-1:0] IDLE_ADDR = 13'h0400;

  // ------------------------------
  // recovery counter
  // ------------------------------
  localparam int CNT_W = 4;

  localparam logic [CNT_W-1:0] CNT_RESET = 4'he;  // window open out of reset

  // normal issue window
  localparam logic [CNT_W-1:0] WIN_NORM_LO = 4'hd;
  localparam logic [CNT_W-1:0] WIN_NORM_HI = 4'he;

  // write recovery before a close, wraps through zero
  localparam logic [CNT_W-1:0] WIN_DLAY_LO = 4'hf;
  localparam logic [CNT_W-1:0] WIN_DLAY_HI = 4'h0;

endpackage

// File: ddr_cmd_top.sv
`timescale 1ns/1ps

module ddr_cmd_top #(
  parameter int unsigned T_CMD_RELOAD = 12,
  parameter int unsigned T_REF_RELOAD = 3
) (
  input  logic                                 input_clock,
  input  logic                                 rst,
  input  logic                                 refresh_strobe,
  // random port
  input  logic [ddr_cmd_pkg::ADDR_W-1:0]       rand_address,
  input  logic                                 rand_we,
  input  logic                                 rand_request,
  input  logic [ddr_cmd_pkg::WE_W-1:0]         rand_we_array,
  output logic                                 rand_grant,
  // bulk port
  input  logic [ddr_cmd_pkg::ADDR_W-1:0]       bulk_address,
  input  logic                                 bulk_we,
  input  logic                                 bulk_request,
  input  logic [ddr_cmd_pkg::WE_W-1:0]         bulk_we_array,
  output logic                                 bulk_grant,
  // sdram command side
  output logic [ddr_cmd_pkg::SDRAM_ADDR_W-1:0] sdram_address,
  output logic [ddr_cmd_pkg::BANK_W-1:0]       sdram_bank,
  output ddr_cmd_pkg::ddr_cmd_e                command,
  output logic [ddr_cmd_pkg::WE_W-1:0]         we_array_out
);

  match_if m_if ();
  state_if s_if ();

  page_matcher u_matcher (
    .input_clock   (input_clock),
    .rst           (rst),
    .rand_address  (rand_address),
    .rand_we       (rand_we),
    .rand_request  (rand_request),
    .rand_we_array (rand_we_array),
    .bulk_address  (bulk_address),
    .bulk_we       (bulk_we),
    .bulk_request  (bulk_request),
    .bulk_we_array (bulk_we_array),
    .m             (m_if.source),
    .s             (s_if.matcher)
  );

  bank_tracker #(
    .T_CMD_RELOAD (T_CMD_RELOAD),
    .T_REF_RELOAD (T_REF_RELOAD)
  ) u_tracker (
    .input_clock    (input_clock),
    .rst            (rst),
    .refresh_strobe (refresh_strobe),
    .s              (s_if.tracker)
  );

  cmd_issuer u_issuer (
    .input_clock   (input_clock),
    .rst           (rst),
    .m             (m_if.sink),
    .s             (s_if.issuer),
    .rand_grant    (rand_grant),
    .bulk_grant    (bulk_grant),
    .sdram_address (sdram_address),
    .sdram_bank    (sdram_bank),
    .command       (command),
    .we_array_out  (we_array_out)
  );

endmodule

// File: match_if.sv
`timescale 1ns/1ps

interface match_if;
  import ddr_cmd_pkg::*;

  logic             rand_hit;
  logic             bulk_hit;
  logic             request_any;  // either port asking
  logic             write_match;
  page_t            next_page;
  logic [COL_W-1:0] next_col;
  logic [WE_W-1:0]  we_array;

  modport source (
    output rand_hit,
    output bulk_hit,
    output request_any,
    output write_match,
    output next_page,
    output next_col,
    output we_array
  );

  modport sink (
    input rand_hit,
    input bulk_hit,
    input request_any,
    input write_match,
    input next_page,
    input next_col,
    input we_array
  );

endinterface

// File: page_matcher.sv
`timescale 1ns/1ps

module page_matcher (
  input  logic                           input_clock,
  input  logic                           rst,
  // random port
  input  logic [ddr_cmd_pkg::ADDR_W-1:0] rand_address,
  input  logic                           rand_we,
  input  logic                           rand_request,
  input  logic [ddr_cmd_pkg::WE_W-1:0]   rand_we_array,
  // bulk port
  input  logic [ddr_cmd_pkg::ADDR_W-1:0] bulk_address,
  input  logic                           bulk_we,
  input  logic                           bulk_request,
  input  logic [ddr_cmd_pkg::WE_W-1:0]   bulk_we_array,
  match_if.source                        m,
  state_if.matcher                       s
);
  import ddr_cmd_pkg::*;

  page_t open_page;
  page_t cand_page;  // page seen at the last edge
  page_t rand_page;
  page_t bulk_page;
  page_t sel_page;
  logic  page_ok;

  assign rand_page = page_t'(rand_address[ADDR_W-1:COL_W]);
  assign bulk_page = page_t'(bulk_address[ADDR_W-1:COL_W]);

  // refresh pending blocks all hits
  assign page_ok = s.page_active && !s.refresh_due;

  // ------------------------------
  // hits, bulk has priority
  // ------------------------------
  assign m.bulk_hit = bulk_request && page_ok && (bulk_page == open_page);
  assign m.rand_hit = rand_request && !bulk_request && page_ok &&
                      (rand_page == open_page);

  assign m.request_any = rand_request || bulk_request;

  assign m.write_match = bulk_request ? bulk_we : (rand_request && rand_we);

  // ------------------------------
  // field select
  // ------------------------------
  assign sel_page    = bulk_request ? bulk_page : rand_page;
  assign m.next_page = sel_page;
  assign m.next_col  = bulk_request ? bulk_address[COL_W-1:0] : rand_address[COL_W-1:0];
  assign m.we_array  = bulk_request ? bulk_we_array : rand_we_array;

  // cand_page holds what the ACTV was issued with, even if the
  // port selection moves in the settle cycle
  always_ff @(posedge input_clock)
  begin
    cand_page <= sel_page;
    if (s.settle && (s.issued_cmd == ACTV))
      open_page <= cand_page;
  end

  // bulk priority must hold through the whole hit path
  a_one_hit : assert property (
    @(posedge input_clock) disable iff (!rst)
    !(m.rand_hit && m.bulk_hit)
  );

endmodule

// File: project.f
ddr_cmd_pkg.sv
match_if.sv
state_if.sv
page_matcher.sv
bank_tracker.sv
cmd_issuer.sv
ddr_cmd_top.sv
tb_ddr_cmd_checks.sv
tb_ddr_cmd.sv

// File: state_if.sv
`timescale 1ns/1ps

interface state_if;
  import ddr_cmd_pkg::*;

  // tracker side
  logic     page_active;
  logic     last_write;
  logic     refresh_due;
  logic     window_open;
  logic     access_open;

  // issuer side
  ddr_cmd_e issued_cmd;
  logic     settle;  // cycle after an issue

  modport tracker (
    output page_active,
    output last_write,
    output refresh_due,
    output window_open,
    output access_open,
    input  issued_cmd,
    input  settle
  );

  modport matcher (
    input page_active,
    input refresh_due,
    input issued_cmd,
    input settle
  );

  modport issuer (
    input  page_active,
    input  last_write,
    input  refresh_due,
    input  window_open,
    input  access_open,
    output issued_cmd,
    output settle
  );

endinterface

// File: tb_ddr_cmd.sv
`timescale 1ns/1ps

module tb_ddr_cmd;
  import ddr_cmd_pkg::*;

  localparam int N_REQ      = 300;
  localparam int MAX_CYCLES = N_REQ * 64 + 800;  // worst case per request plus reset

  logic                    input_clock;
  logic                    rst;
  logic                    refresh_strobe;
  logic [ADDR_W-1:0]       rand_address;
  logic                    rand_we;
  logic                    rand_request;
  logic [WE_W-1:0]         rand_we_array;
  logic                    rand_grant;
  logic [ADDR_W-1:0]       bulk_address;
  logic                    bulk_we;
  logic                    bulk_request;
  logic [WE_W-1:0]         bulk_we_array;
  logic                    bulk_grant;
  logic [SDRAM_ADDR_W-1:0] sdram_address;
  logic [BANK_W-1:0]       sdram_bank;
  ddr_cmd_e                command;
  logic [WE_W-1:0]         we_array_out;

  int    cycles;
  int    done_cnt;
  int    rand_left;
  int    bulk_left;
  logic  refresh_wait;  // toggle sent, ARSR not yet seen
  page_t last_page;

  ddr_cmd_top #(.T_CMD_RELOAD(12), .T_REF_RELOAD(3)) dut_i (.*);

  bind ddr_cmd_top tb_ddr_cmd_checks checks_i (.*);

  task automatic report_failure(input string why);
    $display("Finished with errors");
    $fatal(1, "%s", why);
  endtask

  // small page set, half the time the last page again
  function automatic logic [ADDR_W-1:0] pick_address();
    page_t pg;
    if ($urandom % 2 == 0)
      pg = last_page;
    else
    begin
      case ($urandom % 3)
        0:       pg.row = 12'h000;
        1:       pg.row = 12'h5a3;
        default: pg.row = 12'hc01;
      endcase
      pg.bank = BANK_W'($urandom % 2);
    end
    last_page = pg;
    return {pg, COL_W'($urandom)};
  endfunction

  initial
  begin
    input_clock = 1'b0;
    forever #20 input_clock = ~input_clock;
  end

  // ------------------------------
  // stimulus
  // ------------------------------
  initial
  begin
    void'($urandom(32'hac8915e9));
    rst            = 1'b0;
    refresh_strobe = 1'b0;
    rand_address   = '0;
    rand_we        = 1'b0;
    rand_request   = 1'b0;
    rand_we_array  = '0;
    bulk_address   = '0;
    bulk_we        = 1'b0;
    bulk_request   = 1'b0;
    bulk_we_array  = '0;
    refresh_wait   = 1'b0;
    last_page      = '0;
    done_cnt       = 0;
    rand_left      = N_REQ / 2;
    bulk_left      = N_REQ - N_REQ / 2;
    repeat (10) @(posedge input_clock);
    rst <= 1'b1;
    while (done_cnt < N_REQ)
    begin
      @(posedge input_clock);
      if (rand_request && rand_grant)
      begin
        rand_request <= 1'b0;  // drop right after the grant
        done_cnt++;
      end
      else if (!rand_request && rand_left > 0 && $urandom % 3 == 0)
      begin
        rand_request  <= 1'b1;
        rand_address  <= pick_address();
        rand_we       <= 1'($urandom);
        rand_we_array <= WE_W'($urandom);
        rand_left--;
      end
      if (bulk_request && bulk_grant)
      begin
        bulk_request <= 1'b0;
        done_cnt++;
      end
      else if (!bulk_request && bulk_left > 0 && $urandom % 8 == 0)
      begin
        bulk_request  <= 1'b1;
        bulk_address  <= pick_address();
        bulk_we       <= 1'($urandom);
        bulk_we_array <= WE_W'($urandom);
        bulk_left--;
      end
      if (command == ARSR)
        refresh_wait = 1'b0;
      else if (!refresh_wait && done_cnt > 0 && $urandom % 64 == 0)
      begin
        refresh_strobe <= ~refresh_strobe;
        refresh_wait = 1'b1;
      end
    end
    repeat (4) @(posedge input_clock);
    if (dut_i.checks_i.failed)
      report_failure("a check failed during the run");
    else
    begin
      $display("Finished with no errors");
      $finish;
    end
  end

  initial
  begin
    wait (dut_i.checks_i.failed === 1'b1);
    report_failure("a check in the bound checker failed");
  end

  initial
  begin
    cycles = 0;
    while (cycles < MAX_CYCLES)
    begin
      @(posedge input_clock);
      cycles++;
    end
    report_failure("timeout, not all requests were granted");
  end

endmodule

// File: tb_ddr_cmd_checks.sv
`timescale 1ns/1ps

module tb_ddr_cmd_checks (
  input logic                                 input_clock,
  input logic                                 rst,
  input logic                                 refresh_strobe,
  input logic [ddr_cmd_pkg::ADDR_W-1:0]       rand_address,
  input logic                                 rand_we,
  input logic                                 rand_request,
  input logic [ddr_cmd_pkg::WE_W-1:0]         rand_we_array,
  input logic                                 rand_grant,
  input logic [ddr_cmd_pkg::ADDR_W-1:0]       bulk_address,
  input logic                                 bulk_we,
  input logic                                 bulk_request,
  input logic [ddr_cmd_pkg::WE_W-1:0]         bulk_we_array,
  input logic                                 bulk_grant,
  input logic [ddr_cmd_pkg::SDRAM_ADDR_W-1:0] sdram_address,
  input logic [ddr_cmd_pkg::BANK_W-1:0]       sdram_bank,
  input ddr_cmd_pkg::ddr_cmd_e                command,
  input logic [ddr_cmd_pkg::WE_W-1:0]         we_array_out
);
  import ddr_cmd_pkg::*;

  typedef struct packed {
    logic              req;
    logic              we;
    logic [WE_W-1:0]   wa;
    logic [ADDR_W-1:0] addr;
  } port_t;

  port_t rand_q;  // port levels at the last edge
  port_t bulk_q;
  port_t sel_q;
  port_t gnt_q;
  page_t sel_page;
  page_t gnt_page;
  page_t model_page;
  logic  model_open;
  logic  ref_pend;
  logic  ref_pend_q;
  logic  strobe_q;
  logic  req_seen;
  logic  grant;
  int    since_cmd;
  logic  failed = 1'b0;  // read by the testbench top
  logic [3+BANK_W+SDRAM_ADDR_W+WE_W-1:0] exp_access;

  function automatic logic [SDRAM_ADDR_W-1:0] actv_address(input logic [ROW_W-1:0] row);
    // a10 left clear, upper row bits sit above it
    return (SDRAM_ADDR_W'(row[ROW_W-1:ROW_W-2]) << 11) | SDRAM_ADDR_W'(row[9:0]);
  endfunction

  task automatic value_error(input string name, input logic [31:0] got, input logic [31:0] exp);
    $error("error %0t: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
    failed = 1'b1;
  endtask

  task automatic rule_error(input string what);
    $error("%0t: %s", $time, what);
    failed = 1'b1;
  endtask

  assign sel_q      = bulk_q.req ? bulk_q : rand_q;  // bulk wins
  assign gnt_q      = bulk_grant ? bulk_q : rand_q;
  assign sel_page   = page_t'(sel_q.addr[ADDR_W-1:COL_W]);
  assign gnt_page   = page_t'(gnt_q.addr[ADDR_W-1:COL_W]);
  assign grant      = rand_grant || bulk_grant;
  assign exp_access = {gnt_q.we ? WRTE : READ, gnt_page.bank, gnt_q.addr[COL_W-1:0], 1'b0,
                       gnt_q.wa};

  // ------------------------------
  // open page and refresh model
  // ------------------------------
  always_ff @(posedge input_clock)
  begin
    rand_q     <= '{rand_request, rand_we, rand_we_array, rand_address};
    bulk_q     <= '{bulk_request, bulk_we, bulk_we_array, bulk_address};
    strobe_q   <= refresh_strobe;
    ref_pend_q <= ref_pend;
    if (!rst)
    begin
      model_open <= 1'b0;
      ref_pend   <= 1'b0;
      req_seen   <= 1'b0;
      since_cmd  <= 100;
    end
    else
    begin
      if (rand_request || bulk_request)
        req_seen <= 1'b1;
      if (command == ARSR)
        ref_pend <= 1'b0;
      else if (refresh_strobe != strobe_q)
        ref_pend <= 1'b1;  // toggle seen
      if (command == ACTV)
      begin
        model_open <= 1'b1;
        model_page <= sel_page;
      end
      else if (command == PRCH)
        model_open <= 1'b0;
      since_cmd <= (command != NOOP) ? 1 : since_cmd + 1;
    end
  end

  // ------------------------------
  // checks
  // ------------------------------
  a_reset_idle : assert property (@(posedge input_clock) disable iff (!rst)
    !req_seen |-> {command, grant, sdram_address, we_array_out} ==
                  {NOOP, 1'b0, IDLE_ADDR, {WE_W{1'b0}}})
    else value_error("{command,grant,sdram_address,we_array_out}",
      $sampled({command, grant, sdram_address, we_array_out}),
      {NOOP, 1'b0, IDLE_ADDR, {WE_W{1'b0}}});

  a_actv_page : assert property (@(posedge input_clock) disable iff (!rst)
    command == ACTV |-> {sdram_bank, sdram_address} == {sel_page.bank, actv_address(sel_page.row)})
    else value_error("{sdram_bank,sdram_address}", $sampled({sdram_bank, sdram_address}),
      $sampled({sel_page.bank, actv_address(sel_page.row)}));

  a_actv_closed : assert property (@(posedge input_clock) disable iff (!rst)
    command == ACTV |-> !model_open)
    else rule_error("ACTV issued while a page was still open");

  a_prch_addr : assert property (@(posedge input_clock) disable iff (!rst)
    command == PRCH |-> sdram_address == IDLE_ADDR)
    else value_error("sdram_address", $sampled(sdram_address), IDLE_ADDR);

  a_arsr_closed : assert property (@(posedge input_clock) disable iff (!rst)
    command == ARSR |-> !model_open && ref_pend)
    else rule_error("ARSR issued with a page open or with no refresh due");

  a_access_grant : assert property (@(posedge input_clock) disable iff (!rst)
    command inside {READ, WRTE} |-> grant)
    else rule_error("READ or WRTE issued without a grant");

  a_grant_hit : assert property (@(posedge input_clock) disable iff (!rst)
    grant |-> gnt_q.req && model_open && gnt_page == model_page)
    else rule_error("grant for a port that did not request the open page");

  a_grant_fields : assert property (@(posedge input_clock) disable iff (!rst)
    grant |-> {command, sdram_bank, sdram_address, we_array_out} == exp_access)
    else value_error("{command,sdram_bank,sdram_address,we_array_out}",
      $sampled({command, sdram_bank, sdram_address, we_array_out}), $sampled(exp_access));

  a_bulk_first : assert property (@(posedge input_clock) disable iff (!rst)
    rand_grant |-> !bulk_q.req)
    else rule_error("rand_grant while the bulk port was requesting");

  a_refresh_hold : assert property (@(posedge input_clock) disable iff (!rst)
    ref_pend && ref_pend_q |-> !grant)
    else rule_error("grant while a refresh was due");

  a_spacing : assert property (@(posedge input_clock) disable iff (!rst)
    command != NOOP |-> since_cmd >= 3)
    else rule_error("two commands closer than 3 cycles apart");

endmodule
